// ==== Makefile ====
# Verilator build and run of the OPM decode stage testbench

VERILATOR ?= verilator
TOP       ?= rv32v_decode_tb
SEED      ?= 46709
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
ERR_LIMIT ?= 1000
PASS_MSG  := TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP SEED FLIST OBJ_DIR ERR_LIMIT"

test:
	$(VERILATOR) --binary --timing --assert -Wno-fatal -f $(FLIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR) -o sim
	@out="$$(./$(OBJ_DIR)/sim +verilator+seed+$(SEED) \
		+verilator+error+limit+$(ERR_LIMIT) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
+incdir+verilog
verilog/rv32v_types_pkg.sv
verilog/rv32v_exec_pkg.sv
verilog/rv32v_decode_if.sv
verilog/rv32v_field_split.sv
verilog/rv32v_opm_decode.sv
verilog/rv32v_decode_collect.sv
verilog/rv32v_decode_stage.sv
test/rv32v_decode_asserts.sv
test/rv32v_decode_tb.sv

// ==== test/rv32v_decode_asserts.sv ====
// ********************
// port timing checks for the decode stage
// ********************
`timescale 1ns/1ps
`default_nettype none
`include "rv32v_config.svh"

module rv32v_decode_asserts (
    input logic                          CLK,
    input logic                          rst_n,
    input logic                          in_valid,
    input logic                          out_valid,
    input logic [`RV32V_ISSUE_WIDTH-1:0] out_legal
);
    int unsigned fail_cnt = 0;      // read by the testbench at the end

    reset_clears: assert property (@(posedge CLK)
        !rst_n |=> (!out_valid && (out_legal == '0)))
    else begin
        fail_cnt++;
        $error("out_valid or out_legal still high one cycle into reset");
    end

    // one out_valid pulse per accepted bundle, two edges later
    fixed_latency: assert property (@(posedge CLK) disable iff (!rst_n)
        out_valid == $past(in_valid, 2))
    else begin
        fail_cnt++;
        $error("out_valid does not follow in_valid by two cycles");
    end
endmodule

bind rv32v_decode_stage rv32v_decode_asserts u_asserts (.*);

`default_nettype wire

// ==== test/rv32v_decode_tb.sv ====
// ********************
// decode stage testbench, reference decode and queue check
// ********************
`timescale 1ns/1ps
`default_nettype none
`include "rv32v_config.svh"

module rv32v_decode_tb;
    import rv32v_types_pkg::*;
    import rv32v_exec_pkg::*;

    localparam int W = `RV32V_ISSUE_WIDTH;
    localparam int CLK_PERIOD = 20;
    localparam int STIM_CYCLES = 8 + 128 + 36 + 8 + 200;   // reset plus all tests

    typedef struct packed {
        logic   legal;
        vexec_t vexec;
        vsew_t  veew;
        logic   dmask;
        logic   use_vd;
    } slot_exp_t;
    typedef slot_exp_t [W-1:0] bundle_t;
    typedef instr_t [W-1:0] bundle_w_t;

    logic                 CLK = 1'b0;
    logic                 rst_n;
    logic                 in_valid;
    bundle_w_t            instr;
    vsew_t                vsew;
    logic                 out_valid;
    logic [W-1:0]         out_legal;
    vexec_t [W-1:0]       out_vexec;
    vsew_t [W-1:0]        out_veew_src2;
    logic [W-1:0]         out_disable_mask;
    logic [W-1:0]         out_vuse_vd;

    bundle_t   exp_q[$];
    bundle_t   exp_b;
    string     test_name = "reset";
    int        chk_cnt = 0;
    int        err_cnt = 0;
    int        chk0;
    int        err0;
    int        n;

    rv32v_decode_stage DUT (
        .CLK              (CLK),
        .rst_n            (rst_n),
        .in_valid         (in_valid),
        .instr            (instr),
        .vsew             (vsew),
        .out_valid        (out_valid),
        .out_legal        (out_legal),
        .out_vexec        (out_vexec),
        .out_veew_src2    (out_veew_src2),
        .out_disable_mask (out_disable_mask),
        .out_vuse_vd      (out_vuse_vd)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    function automatic slot_exp_t ref_decode(input instr_t w, input vsew_t sew);
        slot_exp_t  e;
        logic [5:0] f6;
        logic [4:0] vs1;
        logic       ok;
        e = '0;                 // ALU add, unfused, signed, flags clear
        f6 = w[31:26];
        vs1 = w[19:15];
        ok = 1'b1;
        e.veew = sew;
        casez (f6)
            6'b000???: begin
                e.vexec.vfu = VFU_RED;
                e.vexec.vopunsigned = f6[2] & ~f6[0];      // minu, maxu
                case (f6[2:1])
                    2'd0: e.vexec.valuop = f6[0] ? VALU_AND : VALU_ADD;
                    2'd1: e.vexec.valuop = f6[0] ? VALU_XOR : VALU_OR;
                    2'd2: e.vexec.valuop = VALU_MIN;
                    default: e.vexec.valuop = VALU_MAX;
                endcase
            end
            6'b010000: begin
                case (vs1)
                    5'd0: e.vexec.vfu = VFU_PASS_VS2;
                    5'd16, 5'd17: begin
                        e.vexec.vfu = VFU_MSK;
                        e.vexec.vmaskop = vs1[0] ? VMSK_FST : VMSK_CNT;
                    end
                    default: ;
                endcase
            end
            6'b010010: begin
                e.vexec.valuop = VALU_EXT;
                e.vexec.vopunsigned = ~vs1[0];             // zext on even codes
                if (vs1 >= 5'd2 && vs1 <= 5'd7) begin
                    e.veew = sew + vs1[2:1];   // minus 3, 2, 1 is plus 1, 2, 3 mod 4
                end else begin
                    ok = 1'b0;
                end
            end
            6'b011???: begin
                e.dmask = (f6[2:0] != 3'd0);               // all but vmandn
                case (f6[2:0])
                    3'd0: e.vexec.valuop = VALU_ANDN;
                    3'd1: e.vexec.valuop = VALU_AND;
                    3'd2: e.vexec.valuop = VALU_OR;
                    3'd3: e.vexec.valuop = VALU_XOR;
                    3'd5: e.vexec.valuop = VALU_NAND;
                    3'd7: e.vexec.valuop = VALU_XNOR;
                    default: e.vexec.valuop = VALU_NOR;
                endcase
            end
            6'b1000??: begin
                e.vexec.vfu = VFU_DIV;
                case (f6[1:0])
                    2'b00: e.vexec.vopunsigned = 1'b1;      // vdivu
                    2'b10: begin                            // vremu
                        e.vexec.vdivremainder = 1'b1;
                        e.vexec.vopunsigned = 1'b1;
                    end
                    2'b11: e.vexec.vdivremainder = 1'b1;    // vrem
                    default: ;                              // vdiv
                endcase
            end
            6'b1001??: begin
                e.vexec.vfu = VFU_MUL;
                e.vexec.vmulrethigh = (f6[1:0] != 2'b01);  // all but vmul
                e.vexec.vopunsigned = ~f6[0];
                case (f6[1:0])
                    2'b00: e.vexec.vsigntype = UNSIGNED;
                    2'b10: e.vexec.vsigntype = SIGNED_UNSIGNED;
                    default: ;
                endcase
            end
            6'b101??1: begin
                e.vexec.vfu = VFU_MUL;
                e.use_vd = 1'b1;
                case (f6[2:1])
                    2'd0: e.vexec.vmulop = VMUL_MADD;
                    2'd1: e.vexec.vmulop = VMUL_NMSUB;
                    2'd2: e.vexec.vmulop = VMUL_MACC;
                    default: e.vexec.vmulop = VMUL_NMSAC;
                endcase
            end
            6'b110???: begin
                case (f6[1:0])
                    2'b00: e.vexec.vopunsigned = 1'b1;      // vwaddu
                    2'b10: begin                            // vwsubu
                        e.vexec.valuop = VALU_SUB;
                        e.vexec.vopunsigned = 1'b1;
                    end
                    2'b11: e.vexec.valuop = VALU_SUB;       // vwsub
                    default: ;                              // vwadd
                endcase
                if (f6[2]) begin
                    e.veew = sew + 2'd1;                   // .w forms
                end
            end
            default: ok = 1'b0;
        endcase
        if (w[14:12] != 3'd2 && w[14:12] != 3'd6) begin
            ok = 1'b0;
        end
        e.legal = ok && (w[6:0] == 7'b1010111);
        return e;
    endfunction

    // OP-V word, vm, vs2 and vd random
    function automatic instr_t make_word(input logic [5:0] f6, input logic [2:0] f3,
                                         input logic [4:0] vs1);
        return {f6, 1'($urandom), 5'($urandom), vs1, f3, 5'($urandom), 7'b1010111};
    endfunction

    task automatic check_field(input string what, input int slot,
                               input logic [31:0] exp_v, input logic [31:0] act_v);
        chk_cnt++;
        assert (exp_v == act_v)
        else begin
            err_cnt++;
            $error("error %s slot %0d %s: expected %0h actual %0h",
                   test_name, slot, what, exp_v, act_v);
        end
    endtask

    task automatic send_bundle(input bundle_w_t w, input vsew_t s);
        bundle_t e;
        int i;
        @(posedge CLK);
        #2;
        in_valid = 1'b1;
        instr = w;
        vsew = s;
        for (i = 0; i < W; i++) begin
            e[i] = ref_decode(w[i], s);
        end
        exp_q.push_back(e);
    endtask

    task automatic idle();
        @(posedge CLK);
        #2;
        in_valid = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        chk0 = chk_cnt;
        err0 = err_cnt;
    endtask

    task automatic finish_test();
        idle();
        while (exp_q.size() != 0) @(negedge CLK);
        $display("test %-12s done, %0d checks, %0d errors", test_name,
                 chk_cnt - chk0, err_cnt - err0);
    endtask

    // scoreboard, one half period after the output edge
    always @(negedge CLK) begin
        if (rst_n && out_valid) begin
            assert (exp_q.size() != 0)
            else begin
                err_cnt++;
                $error("out_valid pulse in test %s with no bundle pending", test_name);
            end
            if (exp_q.size() != 0) begin
                exp_b = exp_q.pop_front();
                for (n = 0; n < W; n++) begin
                    check_field("legal", n, exp_b[n].legal, out_legal[n]);
                    check_field("vexec", n, exp_b[n].vexec, out_vexec[n]);
                    check_field("veew_src2", n, exp_b[n].veew, out_veew_src2[n]);
                    check_field("disable_mask", n, exp_b[n].dmask, out_disable_mask[n]);
                    check_field("vuse_vd", n, exp_b[n].use_vd, out_vuse_vd[n]);
                end
            end
        end
    end

    initial begin
        #(CLK_PERIOD * (STIM_CYCLES + 50));
        $display("watchdog expired before all bundles came out of the DUT");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        bundle_w_t  w;
        logic [6:0] op;
        int         f;
        int         g;
        int         i;
        int         bad;
        void'($urandom(46709));
        rst_n = 1'b0;
        in_valid = 1'b0;
        instr = '0;
        vsew = '0;
        repeat (8) @(posedge CLK);
        #2;
        rst_n = 1'b1;

        start_test("funct6_sweep");     // all 64 codes, every slot, funct3 2 and 6
        for (f = 0; f < 64; f++) begin
            for (g = 0; g < 2; g++) begin
                for (i = 0; i < W; i++) begin
                    w[i] = make_word(6'(f + i), g ? 3'd6 : 3'd2, 5'($urandom));
                end
                send_bundle(w, 2'($urandom));
            end
        end
        finish_test();

        start_test("ext_widen");
        for (f = 0; f < 4; f++) begin
            for (g = 0; g < 9; g++) begin
                for (i = 0; i < W; i++) begin
                    w[i] = (i % 2 == 0) ? make_word(6'b010010, 3'd2, 5'(g))
                                        : make_word(6'b110100 | 6'(g % 4), 3'd6, 5'($urandom));
                end
                send_bundle(w, 2'(f));
            end
        end
        finish_test();

        start_test("illegal");          // one bad slot per bundle, vmul elsewhere
        for (f = 0; f < 8; f++) begin
            for (i = 0; i < W; i++) begin
                w[i] = make_word(6'b100101, 3'd2, 5'($urandom));
            end
            bad = f % W;
            if (f < 5) begin
                w[bad][14:12] = (f < 2) ? 3'(f) : 3'(f + 1);    // 0, 1, 3, 4, 5
            end else begin
                op = 7'($urandom);
                if (op == 7'b1010111) begin
                    op = op ^ 7'h01;
                end
                w[bad][6:0] = op;
            end
            send_bundle(w, 2'($urandom));
        end
        finish_test();

        start_test("random");
        for (f = 0; f < 200; f++) begin
            if ($urandom % 4 == 0) begin
                idle();
            end else begin
                for (i = 0; i < W; i++) begin
                    w[i] = $urandom;
                    if ($urandom % 4 != 0) begin
                        w[i][6:0] = 7'b1010111;
                        w[i][14:12] = ($urandom % 2 != 0) ? 3'd2 : 3'd6;
                    end
                end
                send_bundle(w, 2'($urandom));
            end
        end
        finish_test();

        $display("checks %0d, errors %0d, assertion failures %0d",
                 chk_cnt, err_cnt, DUT.u_asserts.fail_cnt);
        if (err_cnt == 0 && DUT.u_asserts.fail_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end
endmodule

`default_nettype wire

// ==== verilog/rv32v_config.svh ====
// ********************
// vector decode stage build parameters
// ********************
`ifndef RV32V_CONFIG_SVH
`define RV32V_CONFIG_SVH

// decode slots per bundle, any value of 1 or more
`define RV32V_ISSUE_WIDTH 2

`define RV32V_INSTR_W 32

`endif

// ==== verilog/rv32v_decode_collect.sv ====
// ********************
// output register, legal mask and output strobe
// ********************
`timescale 1ns/1ps
`default_nettype none
`include "rv32v_config.svh"

module rv32v_decode_collect (
    input  logic                                              CLK,
    input  logic                                              rst_n,
    input  logic [`RV32V_ISSUE_WIDTH:0]                       slot_live,
    rv32v_decode_if.collect                                   slot [`RV32V_ISSUE_WIDTH],
    output logic                                              out_valid,
    output logic [`RV32V_ISSUE_WIDTH-1:0]                     out_legal,
    output rv32v_exec_pkg::vexec_t [`RV32V_ISSUE_WIDTH-1:0]   out_vexec,
    output rv32v_types_pkg::vsew_t [`RV32V_ISSUE_WIDTH-1:0]   out_veew_src2,
    output logic [`RV32V_ISSUE_WIDTH-1:0]                     out_disable_mask,
    output logic [`RV32V_ISSUE_WIDTH-1:0]                     out_vuse_vd
);
    import rv32v_exec_pkg::*;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= |slot_live;    // top bit covers an all-illegal bundle
        end
    end

    for (genvar i = 0; i < `RV32V_ISSUE_WIDTH; i++) begin : g_slot
        always_ff @(posedge CLK) begin
            if (!rst_n) begin
                out_legal[i]        <= 1'b0;
                out_vexec[i]        <= VEXEC_DEFAULT;
                out_veew_src2[i]    <= '0;
                out_disable_mask[i] <= 1'b0;
                out_vuse_vd[i]      <= 1'b0;
            end else begin
                out_legal[i] <= slot_live[i] && slot[i].valid;
                if (slot_live[`RV32V_ISSUE_WIDTH]) begin   // hold between bundles
                    out_vexec[i]        <= slot[i].vexec;
                    out_veew_src2[i]    <= slot[i].veew_src2;
                    out_disable_mask[i] <= slot[i].disable_mask;
                    out_vuse_vd[i]      <= slot[i].vuse_vd;
                end
            end
        end
    end
endmodule

`default_nettype wire

// ==== verilog/rv32v_decode_if.sv ====
// ********************
// one decode slot, fields in and controls out
// ********************
`timescale 1ns/1ps
`default_nettype none

interface rv32v_decode_if;
    import rv32v_types_pkg::*;
    import rv32v_exec_pkg::*;

    vopm_t    vopm;
    vfunct3_t vfunct3;
    vsel_t    vs1_sel;
    vsew_t    vsew;

    vexec_t   vexec;
    logic     valid;
    vsew_t    veew_src2;        // element width of vs2
    logic     disable_mask;
    logic     vuse_vd;          // vd read as third source

    modport split (output vopm, vfunct3, vs1_sel, vsew);
    modport dec (input vopm, vfunct3, vs1_sel, vsew,
                 output vexec, valid, veew_src2, disable_mask, vuse_vd);
    modport collect (input vexec, valid, veew_src2, disable_mask, vuse_vd);
endinterface

`default_nettype wire

// ==== verilog/rv32v_decode_stage.sv ====
// ********************
// OPM decode stage top, field split, slot decoders, collector
// ********************
`timescale 1ns/1ps
`default_nettype none
`include "rv32v_config.svh"

module rv32v_decode_stage (
    input  logic                                              CLK,
    input  logic                                              rst_n,
    input  logic                                              in_valid,
    input  rv32v_types_pkg::instr_t [`RV32V_ISSUE_WIDTH-1:0]  instr,
    input  rv32v_types_pkg::vsew_t                            vsew,
    output logic                                              out_valid,
    output logic [`RV32V_ISSUE_WIDTH-1:0]                     out_legal,
    output rv32v_exec_pkg::vexec_t [`RV32V_ISSUE_WIDTH-1:0]   out_vexec,
    output rv32v_types_pkg::vsew_t [`RV32V_ISSUE_WIDTH-1:0]   out_veew_src2,
    output logic [`RV32V_ISSUE_WIDTH-1:0]                     out_disable_mask,
    output logic [`RV32V_ISSUE_WIDTH-1:0]                     out_vuse_vd
);
    logic [`RV32V_ISSUE_WIDTH:0] slot_live;    // per slot, plus bundle flag on top

    rv32v_decode_if slot_if [`RV32V_ISSUE_WIDTH] ();

    rv32v_field_split u_split (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .instr     (instr),
        .vsew      (vsew),
        .slot_live (slot_live),
        .slot      (slot_if)
    );

    for (genvar i = 0; i < `RV32V_ISSUE_WIDTH; i++) begin : g_dec
        rv32v_opm_decode u_dec (
            .dec (slot_if[i])
        );
    end

    rv32v_decode_collect u_collect (
        .CLK              (CLK),
        .rst_n            (rst_n),
        .slot_live        (slot_live),
        .slot             (slot_if),
        .out_valid        (out_valid),
        .out_legal        (out_legal),
        .out_vexec        (out_vexec),
        .out_veew_src2    (out_veew_src2),
        .out_disable_mask (out_disable_mask),
        .out_vuse_vd      (out_vuse_vd)
    );
endmodule

`default_nettype wire

// ==== verilog/rv32v_exec_pkg.sv ====
// ********************
// execution unit control types
// ********************
`default_nettype none

package rv32v_exec_pkg;

    typedef enum logic [2:0] {
        VFU_ALU, VFU_RED, VFU_MSK, VFU_DIV, VFU_MUL, VFU_PASS_VS2
    } vfu_t;

    typedef enum logic [3:0] {
        VALU_ADD, VALU_SUB, VALU_AND, VALU_OR, VALU_XOR, VALU_MIN,
        VALU_MAX, VALU_ANDN, VALU_NAND, VALU_NOR, VALU_XNOR, VALU_EXT
    } valuop_t;

    typedef enum logic [1:0] {VMSK_AND, VMSK_CNT, VMSK_FST} vmaskop_t;

    typedef enum logic [2:0] {
        UNFUSED, VMUL_MADD, VMUL_NMSUB, VMUL_MACC, VMUL_NMSAC
    } vmulop_t;

    typedef enum logic [1:0] {SIGNED, UNSIGNED, SIGNED_UNSIGNED} vsigntype_t;

    typedef struct packed {
        vfu_t       vfu;
        valuop_t    valuop;
        vmulop_t    vmulop;
        logic       vmulrethigh;    // keep upper half of product
        logic       vdivremainder;
        vmaskop_t   vmaskop;
        vsigntype_t vsigntype;
        logic       vopunsigned;
    } vexec_t;

    localparam vexec_t VEXEC_DEFAULT = '{
        vfu: VFU_ALU, valuop: VALU_ADD, vmulop: UNFUSED, vmulrethigh: 1'b0,
        vdivremainder: 1'b0, vmaskop: VMSK_AND, vsigntype: SIGNED, vopunsigned: 1'b0
    };

endpackage

`default_nettype wire

// ==== verilog/rv32v_field_split.sv ====
// ********************
// input register, field extraction and OP-V check
// ********************
`timescale 1ns/1ps
`default_nettype none
`include "rv32v_config.svh"

module rv32v_field_split (
    input  logic                                            CLK,
    input  logic                                            rst_n,
    input  logic                                            in_valid,
    input  rv32v_types_pkg::instr_t [`RV32V_ISSUE_WIDTH-1:0] instr,
    input  rv32v_types_pkg::vsew_t                          vsew,
    output logic [`RV32V_ISSUE_WIDTH:0]                     slot_live,
    rv32v_decode_if.split                                   slot [`RV32V_ISSUE_WIDTH]
);
    import rv32v_types_pkg::*;

    vsew_t vsew_q;      // one vtype per bundle

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            slot_live <= '0;
        end else begin
            slot_live[`RV32V_ISSUE_WIDTH] <= in_valid;     // bundle flag
            for (int i = 0; i < `RV32V_ISSUE_WIDTH; i++) begin
                slot_live[i] <= in_valid && (vopcode_t'(instr[i][6:0]) == VOPC_OPV);
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (in_valid) begin
            vsew_q <= vsew;
        end
    end

    for (genvar i = 0; i < `RV32V_ISSUE_WIDTH; i++) begin : g_slot
        always_ff @(posedge CLK) begin
            if (in_valid) begin
                slot[i].vopm    <= vopm_t'(instr[i][31:26]);
                slot[i].vfunct3 <= vfunct3_t'(instr[i][14:12]);
                slot[i].vs1_sel <= vsel_t'(instr[i][19:15]);
            end
        end
        assign slot[i].vsew = vsew_q;
    end
endmodule

`default_nettype wire

// ==== verilog/rv32v_opm_decode.sv ====
// ********************
// OPM funct6 to execution controls, one slot
// ********************
`timescale 1ns/1ps
`default_nettype none

module rv32v_opm_decode (
    rv32v_decode_if.dec dec
);
    import rv32v_types_pkg::*;
    import rv32v_exec_pkg::*;

    always_comb begin
        dec.valid        = 1'b1;
        dec.veew_src2    = dec.vsew;
        dec.vexec        = VEXEC_DEFAULT;
        dec.disable_mask = 1'b0;
        dec.vuse_vd      = 1'b0;

        case (dec.vopm)
            VREDSUM, VREDAND, VREDOR, VREDXOR,
            VREDMINU, VREDMIN, VREDMAXU, VREDMAX: begin
                dec.vexec.vfu = VFU_RED;
                dec.vexec.vopunsigned = (dec.vopm == VREDMINU) || (dec.vopm == VREDMAXU);
                case (dec.vopm)
                    VREDAND: dec.vexec.valuop = VALU_AND;
                    VREDOR: dec.vexec.valuop = VALU_OR;
                    VREDXOR: dec.vexec.valuop = VALU_XOR;
                    VREDMINU, VREDMIN: dec.vexec.valuop = VALU_MIN;
                    VREDMAXU, VREDMAX: dec.vexec.valuop = VALU_MAX;
                    default: dec.vexec.valuop = VALU_ADD;
                endcase
            end
            VWXUNARY0: begin
                case (dec.vs1_sel)
                    5'b00000: dec.vexec.vfu = VFU_PASS_VS2;    // vmv.x.s
                    5'b10000: begin                             // vcpop
                        dec.vexec.vfu = VFU_MSK;
                        dec.vexec.vmaskop = VMSK_CNT;
                    end
                    5'b10001: begin                             // vfirst
                        dec.vexec.vfu = VFU_MSK;
                        dec.vexec.vmaskop = VMSK_FST;
                    end
                    default: ;
                endcase
            end
            VXUNARY0: begin
                dec.vexec.valuop = VALU_EXT;
                dec.vexec.vopunsigned = ~dec.vs1_sel[0];       // even codes are zext
                case (dec.vs1_sel)
                    5'd2, 5'd3: dec.veew_src2 = dec.vsew - 2'd3;    // vf8
                    5'd4, 5'd5: dec.veew_src2 = dec.vsew - 2'd2;    // vf4
                    5'd6, 5'd7: dec.veew_src2 = dec.vsew - 2'd1;    // vf2
                    default: dec.valid = 1'b0;
                endcase
            end
            VMANDN: dec.vexec.valuop = VALU_ANDN;
            VMAND, VMOR, VMXOR, VMORN, VMNAND, VMNOR, VMXNOR: begin
                dec.disable_mask = 1'b1;
                case (dec.vopm)
                    VMAND: dec.vexec.valuop = VALU_AND;
                    VMOR: dec.vexec.valuop = VALU_OR;
                    VMXOR: dec.vexec.valuop = VALU_XOR;
                    VMNAND: dec.vexec.valuop = VALU_NAND;
                    VMXNOR: dec.vexec.valuop = VALU_XNOR;
                    default: dec.vexec.valuop = VALU_NOR;   // vmorn and vmnor
                endcase
            end
            VDIVU, VDIV, VREMU, VREM: begin
                dec.vexec.vfu = VFU_DIV;
                dec.vexec.vdivremainder = dec.vopm[1];
                dec.vexec.vopunsigned = ~dec.vopm[0];
            end
            VMUL: dec.vexec.vfu = VFU_MUL;
            VMULH: begin
                dec.vexec.vfu = VFU_MUL;
                dec.vexec.vmulrethigh = 1'b1;
            end
            VMULHU: begin
                dec.vexec.vfu = VFU_MUL;
                dec.vexec.vmulrethigh = 1'b1;
                dec.vexec.vsigntype = UNSIGNED;
                dec.vexec.vopunsigned = 1'b1;
            end
            VMULHSU: begin
                dec.vexec.vfu = VFU_MUL;
                dec.vexec.vmulrethigh = 1'b1;
                dec.vexec.vsigntype = SIGNED_UNSIGNED;
                dec.vexec.vopunsigned = 1'b1;
            end
            VMADD, VNMSUB, VMACC, VNMSAC: begin
                dec.vexec.vfu = VFU_MUL;
                dec.vuse_vd = 1'b1;     // accumulator comes from vd
                case (dec.vopm)
                    VMADD: dec.vexec.vmulop = VMUL_MADD;
                    VNMSUB: dec.vexec.vmulop = VMUL_NMSUB;
                    VMACC: dec.vexec.vmulop = VMUL_MACC;
                    default: dec.vexec.vmulop = VMUL_NMSAC;
                endcase
            end
            VWADDU, VWADD, VWSUBU, VWSUB,
            VWADDU_W, VWADD_W, VWSUBU_W, VWSUB_W: begin
                // funct6 bit 1 picks sub, bit 0 clear means unsigned
                dec.vexec.valuop = dec.vopm[1] ? VALU_SUB : VALU_ADD;
                dec.vexec.vopunsigned = ~dec.vopm[0];
                if (dec.vopm[2]) begin
                    dec.veew_src2 = dec.vsew + 2'd1;    // .w form, vs2 already wide
                end
            end
            default: dec.valid = 1'b0;
        endcase

        if ((dec.vfunct3 != VF3_OPMVV) && (dec.vfunct3 != VF3_OPMVX)) begin
            dec.valid = 1'b0;   // OPI and OPF space
        end
    end
endmodule

`default_nettype wire

// ==== verilog/rv32v_types_pkg.sv ====
// ********************
// vector instruction encoding types
// ********************
`default_nettype none
`include "rv32v_config.svh"

package rv32v_types_pkg;

    typedef logic [`RV32V_INSTR_W-1:0] instr_t;
    typedef logic [6:0] vopcode_t;
    typedef logic [2:0] vfunct3_t;
    typedef logic [4:0] vsel_t;     // vs1 field, also selects unary ops
    typedef logic [1:0] vsew_t;     // 0 is 8 bit, 3 is 64 bit

    localparam vopcode_t VOPC_OPV  = 7'b1010111;
    localparam vfunct3_t VF3_OPMVV = 3'd2;
    localparam vfunct3_t VF3_OPMVX = 3'd6;

    // OPM funct6 codes handled by this stage
    typedef enum logic [5:0] {
        VREDSUM   = 6'b000000, VREDAND   = 6'b000001,
        VREDOR    = 6'b000010, VREDXOR   = 6'b000011,
        VREDMINU  = 6'b000100, VREDMIN   = 6'b000101,
        VREDMAXU  = 6'b000110, VREDMAX   = 6'b000111,
        VWXUNARY0 = 6'b010000, VXUNARY0  = 6'b010010,
        VMANDN    = 6'b011000, VMAND     = 6'b011001,
        VMOR      = 6'b011010, VMXOR     = 6'b011011,
        VMORN     = 6'b011100, VMNAND    = 6'b011101,
        VMNOR     = 6'b011110, VMXNOR    = 6'b011111,
        VDIVU     = 6'b100000, VDIV      = 6'b100001,
        VREMU     = 6'b100010, VREM      = 6'b100011,
        VMULHU    = 6'b100100, VMUL      = 6'b100101,
        VMULHSU   = 6'b100110, VMULH     = 6'b100111,
        VMADD     = 6'b101001, VNMSUB    = 6'b101011,
        VMACC     = 6'b101101, VNMSAC    = 6'b101111,
        VWADDU    = 6'b110000, VWADD     = 6'b110001,
        VWSUBU    = 6'b110010, VWSUB     = 6'b110011,
        VWADDU_W  = 6'b110100, VWADD_W   = 6'b110101,
        VWSUBU_W  = 6'b110110, VWSUB_W   = 6'b110111
    } vopm_t;

endpackage

`default_nettype wire
